//--- psx_loader_macros.svh
`ifndef PSX_LOADER_MACROS_SVH
`define PSX_LOADER_MACROS_SVH

// ==============================
// Bus widths
// ==============================

`define PSX_HOST_DATA_W 16
`define PSX_ADDR_W      27
`define PSX_MEM_DATA_W  32
`define PSX_MEM_BE_W    4
`define PSX_CD_SIZE_W   30

// ==============================
// Download placement
// ==============================

// Byte offsets added to the host address
`define PSX_BIOS_BASE   27'h020_0000
`define PSX_EXE_BASE    27'h040_0000

// Host index codes
`define PSX_IDX_BIOS    8'd0
`define PSX_IDX_EXE     8'd1
// Only the low six index bits select the CD
`define PSX_IDX_CD      6'd2

`endif

//--- loader_pkg.sv
`default_nettype none

`include "psx_loader_macros.svh"

package loader_pkg;

	// ==============================
	// Download kinds
	// ==============================

	// Registered from ioctl_download and ioctl_index
	typedef enum logic [1:0] {
		DL_NONE = 2'd0,
		DL_BIOS = 2'd1,
		DL_EXE  = 2'd2,
		DL_CD   = 2'd3
	} download_kind_e;

	// ==============================
	// Word packer
	// ==============================

	// Low half collects, then wait for the memory ack
	typedef enum logic {
		PK_LOW_HALF = 1'b0,
		PK_WAIT_ACK = 1'b1
	} pack_state_e;

	// ==============================
	// Memory write request
	// ==============================

	// One 32-bit write, valid together with its request strobe
	typedef struct packed {
		logic [`PSX_ADDR_W-1:0]     addr;
		logic [`PSX_MEM_DATA_W-1:0] data;
		logic [`PSX_MEM_BE_W-1:0]   be;
	} mem_wr_req_t;

endpackage

`default_nettype wire

//--- media_pkg.sv
`default_nettype none

`include "psx_loader_macros.svh"

package media_pkg;

	// ==============================
	// Media status
	// ==============================

	// CD image and memory card slots as seen by the system
	typedef struct packed {
		logic                      has_cd;
		logic                      cd_on_host;
		logic [`PSX_CD_SIZE_W-1:0] cd_size;
		logic                      card1_mounted;
		logic                      card2_mounted;
	} media_status_t;

	// ==============================
	// Memory card commands
	// ==============================

	// Single-cycle pulses toward the card controllers
	typedef struct packed {
		logic load1;
		logic load2;
		logic save;
	} memcard_cmd_t;

endpackage

`default_nettype wire

//--- download_packer.sv
`default_nettype none

`include "psx_loader_macros.svh"

module download_packer (
	input wire clk_1x,
	input wire rst_n,
	input wire ioctl_download,
	input wire [7:0] ioctl_index,
	input wire [`PSX_ADDR_W-1:0] ioctl_addr,
	input wire [`PSX_HOST_DATA_W-1:0] ioctl_dout,
	input wire ioctl_wr,
	input wire dl_ready,
	output logic ioctl_wait,
	output loader_pkg::download_kind_e dl_kind,
	output loader_pkg::mem_wr_req_t dl_wr,
	output logic dl_req,
	output logic load_exe,
	output logic system_hold
);
	import loader_pkg::*;

	download_kind_e kind_next;
	pack_state_e state;
	logic [`PSX_ADDR_W-1:0] base_offset;
	logic word_take;
	logic is_exe;
	logic was_exe;

	// ==============================
	// Download classification
	// ==============================

	always_comb begin
		kind_next = DL_NONE;
		if (ioctl_download) begin
			if (ioctl_index == `PSX_IDX_BIOS) begin
				kind_next = DL_BIOS;
			end else if (ioctl_index == `PSX_IDX_EXE) begin
				kind_next = DL_EXE;
			end else if (ioctl_index[5:0] == `PSX_IDX_CD) begin
				kind_next = DL_CD;
			end
		end
	end

	// Placement in memory per kind, CD goes to its own port unshifted
	always_comb begin
		case (dl_kind)
			DL_BIOS: base_offset = `PSX_BIOS_BASE;
			DL_EXE: base_offset = `PSX_EXE_BASE;
			default: base_offset = '0;
		endcase
	end

	// Host words only count while idle in a known download
	assign word_take = ioctl_wr && (dl_kind != DL_NONE) && (state == PK_LOW_HALF);

	assign is_exe = (dl_kind == DL_EXE);

	// ==============================
	// Control FSM
	// ==============================

	always_ff @(posedge clk_1x) begin
		if (!rst_n) begin
			dl_kind <= DL_NONE;
			state <= PK_LOW_HALF;
			dl_req <= 1'b0;
			was_exe <= 1'b0;
			load_exe <= 1'b0;
		end else begin
			dl_kind <= kind_next;
			dl_req <= 1'b0;

			case (state)
				PK_LOW_HALF: begin
					// High half completes the pair
					if (word_take && ioctl_addr[1]) begin
						dl_req <= 1'b1;
						state <= PK_WAIT_ACK;
					end
				end
				PK_WAIT_ACK: begin
					// Abandon the wait if the host drops the download
					if (dl_ready || (dl_kind == DL_NONE)) begin
						state <= PK_LOW_HALF;
					end
				end
				default: begin
					state <= PK_LOW_HALF;
				end
			endcase

			// End of executable download starts the loaded program
			was_exe <= is_exe;
			load_exe <= was_exe && !is_exe;
		end
	end

	// ==============================
	// Write payload
	// ==============================

	always_ff @(posedge clk_1x) begin
		if (word_take && !ioctl_addr[1]) begin
			dl_wr.data[`PSX_HOST_DATA_W-1:0] <= ioctl_dout;
			dl_wr.addr <= ioctl_addr + base_offset;
		end
		if (word_take && ioctl_addr[1]) begin
			dl_wr.data[`PSX_MEM_DATA_W-1:`PSX_HOST_DATA_W] <= ioctl_dout;
			dl_wr.be <= '1;
		end
	end

	// Host held from the strobe until the ack is seen
	assign ioctl_wait = (state == PK_WAIT_ACK) && (dl_kind != DL_NONE);

	assign system_hold = (dl_kind != DL_NONE);

endmodule

`default_nettype wire

//--- media_tracker.sv
`default_nettype none

`include "psx_loader_macros.svh"

module media_tracker (
	input wire clk_1x,
	input wire rst_n,
	input wire loader_pkg::download_kind_e dl_kind,
	input wire [`PSX_ADDR_W-1:0] ioctl_addr,
	input wire [2:0] img_mounted,
	input wire [63:0] img_size,
	input wire bk_load,
	input wire bk_save,
	input wire bk_autosave,
	input wire osd_open,
	output media_pkg::media_status_t media,
	output media_pkg::memcard_cmd_t memcard_cmd
);
	import loader_pkg::*;

	logic cd_dl;
	logic cd_dl_q;
	logic img_present;
	logic auto_save;
	logic load_q;
	logic save_q;
	logic auto_save_q;

	assign cd_dl = (dl_kind == DL_CD);
	assign img_present = (img_size != '0);

	// Autosave fires when the menu opens
	assign auto_save = osd_open && bk_autosave;

	always_ff @(posedge clk_1x) begin
		if (!rst_n) begin
			media <= '0;
			memcard_cmd <= '0;
			cd_dl_q <= 1'b0;
			load_q <= 1'b0;
			save_q <= 1'b0;
			auto_save_q <= 1'b0;
		end else begin
			cd_dl_q <= cd_dl;
			load_q <= bk_load;
			save_q <= bk_save;
			auto_save_q <= auto_save;
			memcard_cmd <= '0;

			// ==============================
			// CD image
			// ==============================

			// Image now sits in the aux memory, size from last address
			if (cd_dl_q && !cd_dl) begin
				media.has_cd <= 1'b1;
				media.cd_on_host <= 1'b0;
				media.cd_size <= `PSX_CD_SIZE_W'(ioctl_addr);
			end

			// Slot 0 is the CD, served from the host
			if (img_mounted[0]) begin
				if (img_present) begin
					media.has_cd <= 1'b1;
					media.cd_on_host <= 1'b1;
					media.cd_size <= img_size[`PSX_CD_SIZE_W-1:0];
				end else begin
					media.has_cd <= 1'b0;
				end
			end

			// ==============================
			// Memory cards
			// ==============================

			if (img_mounted[1]) begin
				media.card1_mounted <= img_present;
				if (img_present) begin
					memcard_cmd.load1 <= 1'b1;
				end
			end

			if (img_mounted[2]) begin
				media.card2_mounted <= img_present;
				if (img_present) begin
					memcard_cmd.load2 <= 1'b1;
				end
			end

			// Reload request hits both cards
			if (bk_load && !load_q) begin
				memcard_cmd.load1 <= 1'b1;
				memcard_cmd.load2 <= 1'b1;
			end

			if ((bk_save && !save_q) || (auto_save && !auto_save_q)) begin
				memcard_cmd.save <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- main_write_arbiter.sv
`default_nettype none

module main_write_arbiter (
	input wire clk_1x,
	input wire rst_n,
	input wire loader_pkg::download_kind_e dl_kind,
	input wire loader_pkg::mem_wr_req_t dl_wr,
	input wire dl_req,
	input wire loader_pkg::mem_wr_req_t sys_wr,
	input wire sys_req,
	input wire main_ready,
	input wire aux_ready,
	output logic dl_ready,
	output logic sys_ready,
	output loader_pkg::mem_wr_req_t main_wr,
	output logic main_req,
	output loader_pkg::mem_wr_req_t aux_wr,
	output logic aux_req
);
	import loader_pkg::*;

	logic dl_wants_main;
	logic owner_dl;
	logic owner_dl_q;
	logic outstanding_q;

	// BIOS and executable images live in main memory
	assign dl_wants_main = (dl_kind == DL_BIOS) || (dl_kind == DL_EXE);

	// Ownership frozen while a write is in flight
	assign owner_dl = outstanding_q ? owner_dl_q : dl_wants_main;

	// ==============================
	// Main port
	// ==============================

	// A system request seen under packer ownership is dropped
	assign main_req = owner_dl ? (dl_req && dl_wants_main) : sys_req;
	assign main_wr = owner_dl ? dl_wr : sys_wr;

	assign sys_ready = main_ready && outstanding_q && !owner_dl_q;

	// ==============================
	// Aux port
	// ==============================

	// CD writes only
	assign aux_req = dl_req && (dl_kind == DL_CD);
	assign aux_wr = dl_wr;

	// Packer is acked by whichever port took its write
	assign dl_ready = (main_ready && outstanding_q && owner_dl_q) || aux_ready;

	always_ff @(posedge clk_1x) begin
		if (!rst_n) begin
			owner_dl_q <= 1'b0;
			outstanding_q <= 1'b0;
		end else begin
			owner_dl_q <= owner_dl;
			outstanding_q <= main_req || (outstanding_q && !main_ready);
		end
	end

endmodule

`default_nettype wire

//--- psx_loader_top.sv
`default_nettype none

`include "psx_loader_macros.svh"

module psx_loader_top (
	input wire clk_1x,
	input wire rst_n,
	// Host download channel
	input wire ioctl_download,
	input wire [7:0] ioctl_index,
	input wire [`PSX_ADDR_W-1:0] ioctl_addr,
	input wire [`PSX_HOST_DATA_W-1:0] ioctl_dout,
	input wire ioctl_wr,
	output wire ioctl_wait,
	// Image slots and card controls
	input wire [2:0] img_mounted,
	input wire [63:0] img_size,
	input wire bk_load,
	input wire bk_save,
	input wire bk_autosave,
	input wire osd_open,
	// Emulated system as write client
	input wire loader_pkg::mem_wr_req_t sys_wr,
	input wire sys_req,
	output wire sys_ready,
	// Memory ports
	output wire loader_pkg::mem_wr_req_t main_wr,
	output wire main_req,
	input wire main_ready,
	output wire loader_pkg::mem_wr_req_t aux_wr,
	output wire aux_req,
	input wire aux_ready,
	// System control
	output wire load_exe,
	output wire system_hold,
	output wire media_pkg::media_status_t media,
	output wire media_pkg::memcard_cmd_t memcard_cmd
);
	import loader_pkg::*;

	download_kind_e dl_kind;
	mem_wr_req_t dl_wr;
	logic dl_req;
	logic dl_ready;

	download_packer u_packer (
		.clk_1x(clk_1x),
		.rst_n(rst_n),
		.ioctl_download(ioctl_download),
		.ioctl_index(ioctl_index),
		.ioctl_addr(ioctl_addr),
		.ioctl_dout(ioctl_dout),
		.ioctl_wr(ioctl_wr),
		.dl_ready(dl_ready),
		.ioctl_wait(ioctl_wait),
		.dl_kind(dl_kind),
		.dl_wr(dl_wr),
		.dl_req(dl_req),
		.load_exe(load_exe),
		.system_hold(system_hold)
	);

	media_tracker u_media (
		.clk_1x(clk_1x),
		.rst_n(rst_n),
		.dl_kind(dl_kind),
		.ioctl_addr(ioctl_addr),
		.img_mounted(img_mounted),
		.img_size(img_size),
		.bk_load(bk_load),
		.bk_save(bk_save),
		.bk_autosave(bk_autosave),
		.osd_open(osd_open),
		.media(media),
		.memcard_cmd(memcard_cmd)
	);

	main_write_arbiter u_arbiter (
		.clk_1x(clk_1x),
		.rst_n(rst_n),
		.dl_kind(dl_kind),
		.dl_wr(dl_wr),
		.dl_req(dl_req),
		.sys_wr(sys_wr),
		.sys_req(sys_req),
		.main_ready(main_ready),
		.aux_ready(aux_ready),
		.dl_ready(dl_ready),
		.sys_ready(sys_ready),
		.main_wr(main_wr),
		.main_req(main_req),
		.aux_wr(aux_wr),
		.aux_req(aux_req)
	);

endmodule

`default_nettype wire

//--- tb_mem_responder.sv
`default_nettype none

module tb_mem_responder (
	input wire clk_1x,
	input wire rst_n,
	input wire loader_pkg::mem_wr_req_t wr,
	input wire req,
	output logic ready,
	output int unsigned logged
);
	import loader_pkg::*;

	// Every accepted write, in arrival order
	mem_wr_req_t writes[$];
	integer seed = 32'h1029_a175;
	int delay;

	initial begin
		ready = 1'b0;
		logged = 0;
		forever begin
			// Requests are combinational from DUT registers, so look mid-cycle
			@(negedge clk_1x);
			if (rst_n && req) begin
				writes.push_back(wr);
				logged = writes.size();
				delay = 1 + ({$random(seed)} % 6);
				// Ready lands 1 to 6 cycles after the request cycle
				repeat (delay) @(posedge clk_1x);
				#1 ready = 1'b1;
				@(posedge clk_1x);
				#1 ready = 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

//--- tb_psx_loader.sv
`default_nettype none

`include "psx_loader_macros.svh"

module tb_psx_loader;
	import loader_pkg::*;
	import media_pkg::*;

	// Three downloads of at most 15 pairs of well under 20 cycles each
	// plus system writes, mounts and card commands leave a wide margin
	localparam int WATCHDOG_CYCLES = 20000;

	logic clk_1x = 1'b0;
	logic rst_n = 1'b0;
	logic ioctl_download = 1'b0;
	logic [7:0] ioctl_index = 8'd0;
	logic [`PSX_ADDR_W-1:0] ioctl_addr = '0;
	logic [`PSX_HOST_DATA_W-1:0] ioctl_dout = '0;
	logic ioctl_wr = 1'b0;
	logic [2:0] img_mounted = 3'b000;
	logic [63:0] img_size = '0;
	logic bk_load = 1'b0;
	logic bk_save = 1'b0;
	logic bk_autosave = 1'b0;
	logic osd_open = 1'b0;
	mem_wr_req_t sys_wr = '0;
	logic sys_req = 1'b0;
	logic ioctl_wait;
	logic sys_ready;
	mem_wr_req_t main_wr;
	logic main_req;
	logic main_ready;
	mem_wr_req_t aux_wr;
	logic aux_req;
	logic aux_ready;
	logic load_exe;
	logic system_hold;
	media_status_t media;
	memcard_cmd_t memcard_cmd;

	integer seed = 32'h1029_a175;
	mem_wr_req_t exp_main[$];
	mem_wr_req_t exp_aux[$];
	mem_wr_req_t want;
	int unsigned main_logged;
	int unsigned aux_logged;
	int unsigned n_main = 0;
	int unsigned n_aux = 0;
	int load_exe_cnt = 0;
	int load1_cnt = 0;
	int load2_cnt = 0;
	int save_cnt = 0;
	int sys_ready_cnt = 0;
	logic [`PSX_ADDR_W-1:0] last_addr = '0;

	always #5 clk_1x = ~clk_1x;

	psx_loader_top dut (.*);

	tb_mem_responder main_mem (
		.clk_1x(clk_1x),
		.rst_n(rst_n),
		.wr(main_wr),
		.req(main_req),
		.ready(main_ready),
		.logged(main_logged)
	);

	tb_mem_responder aux_mem (
		.clk_1x(clk_1x),
		.rst_n(rst_n),
		.wr(aux_wr),
		.req(aux_req),
		.ready(aux_ready),
		.logged(aux_logged)
	);

	task automatic report_fail(input string msg);
		$display("Fail at time %0t: %s", $time, msg);
		$display("CHECKS FAILED");
		$fatal(1);
	endtask

	task automatic step();
		@(posedge clk_1x);
		#1;
	endtask

	task automatic check_count(input string what, input int got, input int expected);
		assert (got == expected)
			else report_fail($sformatf("%s count is %0d, expected %0d", what, got, expected));
	endtask

	// ==============================
	// Protocol checks
	// ==============================

	assert property (@(negedge clk_1x) disable iff (!rst_n)
		(ioctl_wr && ioctl_addr[1] && system_hold) |=> ioctl_wait)
		else report_fail("ioctl_wait did not rise after a high-half host word");
	assert property (@(negedge clk_1x) disable iff (!rst_n)
		(ioctl_wait && (main_ready || aux_ready)) |=> !ioctl_wait)
		else report_fail("ioctl_wait did not fall after the memory ready");
	assert property (@(negedge clk_1x) disable iff (!rst_n)
		(ioctl_wait && !main_ready && !aux_ready) |=> ioctl_wait)
		else report_fail("ioctl_wait fell before any memory ready");
	assert property (@(negedge clk_1x) disable iff (!rst_n)
		!system_hold |-> !ioctl_wait)
		else report_fail("ioctl_wait is high with no download running");
	assert property (@(negedge clk_1x) disable iff (!rst_n)
		ioctl_download |=> system_hold)
		else report_fail("system_hold is low during a download");
	assert property (@(negedge clk_1x) disable iff (!rst_n)
		!ioctl_download |=> !system_hold)
		else report_fail("system_hold stayed high after the download ended");

	// Pulse counters and port compares at mid-cycle where outputs are settled
	always @(negedge clk_1x) begin
		if (load_exe) load_exe_cnt++;
		if (memcard_cmd.load1) load1_cnt++;
		if (memcard_cmd.load2) load2_cnt++;
		if (memcard_cmd.save) save_cnt++;
		if (sys_ready) sys_ready_cnt++;
		if (rst_n && main_req) begin
			assert (exp_main.size() > 0)
				else report_fail("Unexpected write on the main port");
			want = exp_main.pop_front();
			assert (main_wr == want)
				else report_fail($sformatf("main port wrote %h, expected %h", main_wr, want));
		end
		if (rst_n && aux_req) begin
			assert (exp_aux.size() > 0)
				else report_fail("Unexpected write on the aux port");
			want = exp_aux.pop_front();
			assert (aux_wr == want)
				else report_fail($sformatf("aux port wrote %h, expected %h", aux_wr, want));
		end
	end

	// ==============================
	// Host and system models
	// ==============================

	task automatic send_word(input logic [`PSX_ADDR_W-1:0] addr,
			input logic [`PSX_HOST_DATA_W-1:0] data);
		// Host holds off while the loader waits for memory
		while (ioctl_wait) step();
		ioctl_addr = addr;
		ioctl_dout = data;
		ioctl_wr = 1'b1;
		step();
		ioctl_wr = 1'b0;
	endtask

	task automatic sys_write(input bit acked);
		mem_wr_req_t w;
		int ready_seen;
		w.addr = 27'($random(seed));
		w.data = $random(seed);
		w.be = 4'($random(seed));
		ready_seen = sys_ready_cnt;
		if (acked) exp_main.push_back(w);
		if (acked) n_main++;
		sys_wr = w;
		sys_req = 1'b1;
		step();
		sys_req = 1'b0;
		if (acked) begin
			while (sys_ready_cnt == ready_seen) step();
		end
		// A dropped write gets longer than the slowest ready to show up
		repeat (acked ? 1 : 8) step();
	endtask

	task automatic run_download(input logic [7:0] index, input download_kind_e kind,
			input bit with_sys);
		int pairs;
		logic [`PSX_ADDR_W-1:0] addr;
		logic [`PSX_ADDR_W-1:0] base;
		logic [`PSX_HOST_DATA_W-1:0] lo;
		logic [`PSX_HOST_DATA_W-1:0] hi;
		mem_wr_req_t w;
		pairs = 8 + ({$random(seed)} % 8);
		base = (kind == DL_BIOS) ? `PSX_BIOS_BASE
			: ((kind == DL_EXE) ? `PSX_EXE_BASE : '0);
		ioctl_index = index;
		ioctl_download = 1'b1;
		repeat (2) step();
		for (int i = 0; i < pairs; i++) begin
			addr = 27'(4 * i);
			lo = 16'($random(seed));
			hi = 16'($random(seed));
			w.addr = addr + base;
			w.data = {hi, lo};
			w.be = 4'hf;
			if (kind == DL_CD) begin
				exp_aux.push_back(w);
				n_aux++;
			end else begin
				exp_main.push_back(w);
				n_main++;
			end
			send_word(addr, lo);
			send_word(addr + 27'd2, hi);
			// System write while the packer owns the main port
			if (with_sys && i == 0) sys_write(1'b0);
		end
		while (ioctl_wait) step();
		last_addr = ioctl_addr;
		ioctl_download = 1'b0;
		repeat (4) step();
		assert (exp_main.size() == 0 && exp_aux.size() == 0)
			else report_fail("Some download writes never reached a memory port");
	endtask

	task automatic mount_image(input int slot, input logic [63:0] size);
		img_size = size;
		img_mounted = 3'(1 << slot);
		step();
		img_mounted = 3'b000;
		repeat (3) step();
	endtask

	// ==============================
	// Test sequence
	// ==============================

	initial begin
		repeat (16) @(posedge clk_1x);
		#1 rst_n = 1'b1;
		step();
		assert (!ioctl_wait && !load_exe && !system_hold && !main_req && !aux_req
				&& !sys_ready && memcard_cmd == '0 && media == '0)
			else report_fail("Outputs are not idle after reset");

		repeat (4) sys_write(1'b1);
		check_count("sys_ready", sys_ready_cnt, 4);

		run_download(`PSX_IDX_BIOS, DL_BIOS, 1'b1);
		check_count("sys_ready", sys_ready_cnt, 4);
		check_count("load_exe", load_exe_cnt, 0);
		run_download(`PSX_IDX_EXE, DL_EXE, 1'b0);
		check_count("load_exe", load_exe_cnt, 1);

		// Upper index bits are ignored for the CD
		run_download({2'b01, `PSX_IDX_CD}, DL_CD, 1'b0);
		assert (media.has_cd && !media.cd_on_host && media.cd_size == 30'(last_addr))
			else report_fail($sformatf("CD status after download is %h", media));

		mount_image(1, 64'd131072);
		mount_image(2, 64'd131072);
		assert (media.card1_mounted && media.card2_mounted)
			else report_fail("Card mount did not set the mounted bits");
		check_count("load1", load1_cnt, 1);
		check_count("load2", load2_cnt, 1);
		mount_image(1, 64'd0);
		assert (!media.card1_mounted && media.card2_mounted)
			else report_fail("Empty card mount did not clear card 1");
		check_count("load1", load1_cnt, 1);
		mount_image(0, 64'd0);
		assert (!media.has_cd)
			else report_fail("Empty CD mount did not clear has_cd");
		mount_image(0, 64'd12_345_678);
		assert (media.has_cd && media.cd_on_host && media.cd_size == 30'd12_345_678)
			else report_fail($sformatf("CD status after mount is %h", media));

		// Held levels must give a single pulse each
		bk_load = 1'b1;
		repeat (6) step();
		check_count("load1", load1_cnt, 2);
		check_count("load2", load2_cnt, 2);
		bk_save = 1'b1;
		repeat (6) step();
		check_count("save", save_cnt, 1);

		// Menu opening saves only with autosave on
		osd_open = 1'b1;
		repeat (4) step();
		check_count("save", save_cnt, 1);
		osd_open = 1'b0;
		bk_autosave = 1'b1;
		repeat (2) step();
		osd_open = 1'b1;
		repeat (6) step();
		check_count("save", save_cnt, 2);

		if (main_logged == n_main && aux_logged == n_aux) begin
			$display("ALL CHECKS PASSED");
			$finish;
		end else begin
			report_fail("Memory port logs do not match the writes that were issued");
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk_1x);
		$display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("CHECKS FAILED");
		$fatal(1);
	end

endmodule

`default_nettype wire

//--- flist.f
+incdir+.
loader_pkg.sv
media_pkg.sv
download_packer.sv
media_tracker.sv
main_write_arbiter.sv
psx_loader_top.sv
tb_mem_responder.sv
tb_psx_loader.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the loader testbench with Verilator, run it, and check the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_psx_loader -f flist.f -Mdir obj_dir \
	&& ./obj_dir/Vtb_psx_loader > sim.log 2>&1
grep -q "ALL CHECKS PASSED" sim.log && echo "Simulation passed" \
	|| { echo "Simulation failed, see sim.log"; exit 1; }
